// ==== logic/ex_cfg.svh ====
// fixed RV64 integer widths; changing XLEN alone is not supported by the word-operation logic
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// data path width
`define XLEN 64

// register file address width, 32 entries
`define REG_AW 5

// instruction word width
`define INST_W 32

`endif

// ==== logic/ex_pkg.sv ====
// RV64I integer subset only; opcode values follow the base RISC-V encoding
package ex_pkg;

  // R-type field layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // I-type field layout, immediate in the upper 12 bits
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // one instruction word seen as R-type or I-type
  typedef union packed {
    r_fmt_t r_view;
    i_fmt_t i_view;
  } inst_u;

  localparam logic [3:0] ALU_ADD  = 4'd0;
  localparam logic [3:0] ALU_SUB  = 4'd1;
  localparam logic [3:0] ALU_SLL  = 4'd2;
  localparam logic [3:0] ALU_SLT  = 4'd3;
  localparam logic [3:0] ALU_SLTU = 4'd4;
  localparam logic [3:0] ALU_XOR  = 4'd5;
  localparam logic [3:0] ALU_SRL  = 4'd6;
  localparam logic [3:0] ALU_SRA  = 4'd7;
  localparam logic [3:0] ALU_OR   = 4'd8;
  localparam logic [3:0] ALU_AND  = 4'd9;
  localparam logic [3:0] ALU_LUI  = 4'd10;

  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;

endpackage

// ==== logic/id_decode.sv ====
// decodes OP, OP-IMM, OP-32, OP-IMM-32 and lui only; anything else is flagged illegal
`timescale 1ns/1ps
`include "ex_cfg.svh"

module id_decode import ex_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  logic [`INST_W-1:0] in_inst,
  output logic               in_ready,
  output logic               id_to_ex_valid,
  output logic [3:0]         id_alu_op,
  output logic [`REG_AW-1:0] id_rs1,
  output logic [`REG_AW-1:0] id_rs2,
  output logic               id_use_rs2,
  output logic [`XLEN-1:0]   id_imm,
  output logic               id_is_word,
  output logic [`REG_AW-1:0] id_rd,
  output logic               id_wen,
  output logic               id_illegal,
  input  logic               ex_allowin
);

  inst_u            inst;
  logic             id_valid;
  logic [3:0]       dec_op;
  logic             dec_use_rs2;
  logic             dec_is_word;
  logic             dec_illegal;
  logic [`XLEN-1:0] dec_imm;
  logic             f7_zero;
  logic             f7_alt;

  assign inst    = in_inst;
  assign f7_zero = inst.r_view.funct7 == 7'b0000000;
  assign f7_alt  = inst.r_view.funct7 == 7'b0100000;

  always_comb begin
    dec_op      = ALU_ADD;
    dec_use_rs2 = 1'b0;
    dec_is_word = 1'b0;
    dec_illegal = 1'b0;
    dec_imm     = {{(`XLEN-12){inst.i_view.imm12[11]}}, inst.i_view.imm12};
    case (inst.r_view.opcode)
      OPC_OP_IMM: begin
        case (inst.i_view.funct3)
          3'b000: dec_op = ALU_ADD;
          3'b001: begin
            dec_op      = ALU_SLL;
            dec_illegal = inst.i_view.imm12[11:6] != 6'b0;
          end
          3'b010: dec_op = ALU_SLT;
          3'b011: dec_op = ALU_SLTU;
          3'b100: dec_op = ALU_XOR;
          3'b101: begin
            // imm12[10] picks srai, the 6-bit shamt sits below
            dec_op      = inst.i_view.imm12[10] ? ALU_SRA : ALU_SRL;
            dec_illegal = {inst.i_view.imm12[11], inst.i_view.imm12[9:6]} != 5'b0;
          end
          3'b110: dec_op = ALU_OR;
          default: dec_op = ALU_AND;
        endcase
      end
      OPC_OP, OPC_OP_32: begin
        dec_use_rs2 = 1'b1;
        dec_is_word = inst.r_view.opcode == OPC_OP_32;
        case (inst.r_view.funct3)
          3'b000: dec_op = f7_alt ? ALU_SUB : ALU_ADD;
          3'b001: dec_op = ALU_SLL;
          3'b010: dec_op = ALU_SLT;
          3'b011: dec_op = ALU_SLTU;
          3'b100: dec_op = ALU_XOR;
          3'b101: dec_op = f7_alt ? ALU_SRA : ALU_SRL;
          3'b110: dec_op = ALU_OR;
          default: dec_op = ALU_AND;
        endcase
        // funct7 0100000 only valid for sub and sra
        dec_illegal = !(f7_zero ||
                        (f7_alt && (inst.r_view.funct3 == 3'b000 ||
                                    inst.r_view.funct3 == 3'b101)));
        // word forms exist only for add/sub, sll and srl/sra
        if (dec_is_word && inst.r_view.funct3 != 3'b000 &&
            inst.r_view.funct3 != 3'b001 && inst.r_view.funct3 != 3'b101) begin
          dec_illegal = 1'b1;
        end
      end
      OPC_OP_IMM_32: begin
        dec_is_word = 1'b1;
        // funct7 covers shamt[5], which must be zero for word shifts
        case (inst.r_view.funct3)
          3'b000: dec_op = ALU_ADD;
          3'b001: begin
            dec_op      = ALU_SLL;
            dec_illegal = !f7_zero;
          end
          3'b101: begin
            dec_op      = f7_alt ? ALU_SRA : ALU_SRL;
            dec_illegal = !(f7_zero || f7_alt);
          end
          default: dec_illegal = 1'b1;
        endcase
      end
      OPC_LUI: begin
        dec_op  = ALU_LUI;
        dec_imm = {{(`XLEN-32){in_inst[31]}}, in_inst[31:12], 12'b0};
      end
      default: dec_illegal = 1'b1;
    endcase
  end

  assign in_ready       = !id_valid || ex_allowin;
  assign id_to_ex_valid = id_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;
    end else if (in_ready) begin
      id_valid <= in_valid;
    end
  end

  // decoded payload, loaded on each accepted instruction
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      id_alu_op  <= dec_op;
      id_rs1     <= inst.r_view.rs1;
      id_rs2     <= inst.r_view.rs2;
      id_use_rs2 <= dec_use_rs2;
      id_imm     <= dec_imm;
      id_is_word <= dec_is_word;
      id_rd      <= inst.r_view.rd;
      id_wen     <= !dec_illegal;
      id_illegal <= dec_illegal;
    end
  end

endmodule

// ==== logic/ex_alu.sv ====
// purely combinational; word mode assumes XLEN 64 and always sign-extends bit 31 of the result
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_alu import ex_pkg::*; (
  input  logic [`XLEN-1:0] op1,
  input  logic [`XLEN-1:0] op2,
  input  logic [3:0]       alu_op,
  input  logic             is_word,
  output logic [`XLEN-1:0] result
);

  logic [5:0]       shamt;
  logic [`XLEN-1:0] sr_src;
  logic [`XLEN-1:0] raw;

  // word shifts use only 5 bits of amount
  assign shamt = is_word ? {1'b0, op2[4:0]} : op2[5:0];

  // right shifts in word mode see only the low word of op1
  always_comb begin
    sr_src = op1;
    if (is_word) begin
      if (alu_op == ALU_SRA) begin
        sr_src = {{(`XLEN-32){op1[31]}}, op1[31:0]};
      end else begin
        sr_src = {{(`XLEN-32){1'b0}}, op1[31:0]};
      end
    end
  end

  always_comb begin
    case (alu_op)
      ALU_ADD:  raw = op1 + op2;
      ALU_SUB:  raw = op1 - op2;
      ALU_SLL:  raw = op1 << shamt;
      ALU_SLT:  raw = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
      ALU_SLTU: raw = {{(`XLEN-1){1'b0}}, op1 < op2};
      ALU_XOR:  raw = op1 ^ op2;
      ALU_SRL:  raw = sr_src >> shamt;
      ALU_SRA:  raw = $unsigned($signed(sr_src) >>> shamt);
      ALU_OR:   raw = op1 | op2;
      ALU_AND:  raw = op1 & op2;
      // immediate already shifted into place by decode
      ALU_LUI:  raw = op2;
      default:  raw = op1 + op2;
    endcase
  end

  // word results: keep low 32 bits, sign-extend bit 31
  always_comb begin
    if (is_word) begin
      result = {{(`XLEN-32){raw[31]}}, raw[31:0]};
    end else begin
      result = raw;
    end
  end

endmodule

// ==== logic/ex_stage.sv ====
// never stalls on data hazards; relies on mem and wb forwarding since there are no loads
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage import ex_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               id_to_ex_valid,
  input  logic [3:0]         id_alu_op,
  input  logic [`REG_AW-1:0] id_rs1,
  input  logic [`REG_AW-1:0] id_rs2,
  input  logic               id_use_rs2,
  input  logic [`XLEN-1:0]   id_imm,
  input  logic               id_is_word,
  input  logic [`REG_AW-1:0] id_rd,
  input  logic               id_wen,
  input  logic               id_illegal,
  output logic               ex_allowin,
  output logic [`REG_AW-1:0] rs1_addr,
  output logic [`REG_AW-1:0] rs2_addr,
  input  logic [`XLEN-1:0]   rs1_data,
  input  logic [`XLEN-1:0]   rs2_data,
  input  logic               mem_fwd_ena,
  input  logic [`REG_AW-1:0] mem_fwd_addr,
  input  logic [`XLEN-1:0]   mem_fwd_data,
  input  logic               wb_fwd_ena,
  input  logic [`REG_AW-1:0] wb_fwd_addr,
  input  logic [`XLEN-1:0]   wb_fwd_data,
  output logic               ex_to_mem_valid,
  output logic [`XLEN-1:0]   ex_result,
  output logic [`REG_AW-1:0] ex_rd,
  output logic               ex_wen,
  output logic               ex_illegal,
  input  logic               mem_allowin
);

  logic               ex_valid;
  logic [3:0]         ex_alu_op_r;
  logic [`REG_AW-1:0] ex_rs1_r;
  logic [`REG_AW-1:0] ex_rs2_r;
  logic               ex_use_rs2_r;
  logic [`XLEN-1:0]   ex_imm_r;
  logic               ex_is_word_r;
  logic [`XLEN-1:0]   rs1_fwd;
  logic [`XLEN-1:0]   rs2_fwd;
  logic [`XLEN-1:0]   alu_op2;

  // single-cycle execute so ready as soon as mem can take it
  assign ex_allowin      = !ex_valid || mem_allowin;
  assign ex_to_mem_valid = ex_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid <= id_to_ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (id_to_ex_valid && ex_allowin) begin
      ex_alu_op_r  <= id_alu_op;
      ex_rs1_r     <= id_rs1;
      ex_rs2_r     <= id_rs2;
      ex_use_rs2_r <= id_use_rs2;
      ex_imm_r     <= id_imm;
      ex_is_word_r <= id_is_word;
      ex_rd        <= id_rd;
      ex_wen       <= id_wen;
      ex_illegal   <= id_illegal;
    end
  end

  assign rs1_addr = ex_rs1_r;
  assign rs2_addr = ex_rs2_r;

  // newest producer wins with mem over wb over register file
  function automatic logic [`XLEN-1:0] fwd_sel(
    input logic [`REG_AW-1:0] addr,
    input logic [`XLEN-1:0]   rf_data
  );
    logic [`XLEN-1:0] val;
    val = rf_data;
    if (addr != '0 && wb_fwd_ena && wb_fwd_addr == addr) begin
      val = wb_fwd_data;
    end
    if (addr != '0 && mem_fwd_ena && mem_fwd_addr == addr) begin
      val = mem_fwd_data;
    end
    return val;
  endfunction

  always_comb begin
    rs1_fwd = fwd_sel(rs1_addr, rs1_data);
    rs2_fwd = fwd_sel(rs2_addr, rs2_data);
  end

  assign alu_op2 = ex_use_rs2_r ? rs2_fwd : ex_imm_r;

  ex_alu u_ex_alu (
    .op1     (rs1_fwd),
    .op2     (alu_op2),
    .alu_op  (ex_alu_op_r),
    .is_word (ex_is_word_r),
    .result  (ex_result)
  );

endmodule

// ==== logic/wb_stage.sv ====
// register file has no reset and x0 always reads zero; commit holds while commit_ready is low
`timescale 1ns/1ps
`include "ex_cfg.svh"

module wb_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               ex_to_mem_valid,
  input  logic [`XLEN-1:0]   ex_result,
  input  logic [`REG_AW-1:0] ex_rd,
  input  logic               ex_wen,
  input  logic               ex_illegal,
  output logic               mem_allowin,
  input  logic [`REG_AW-1:0] rs1_addr,
  input  logic [`REG_AW-1:0] rs2_addr,
  output logic [`XLEN-1:0]   rs1_data,
  output logic [`XLEN-1:0]   rs2_data,
  output logic               mem_fwd_ena,
  output logic [`REG_AW-1:0] mem_fwd_addr,
  output logic [`XLEN-1:0]   mem_fwd_data,
  output logic               wb_fwd_ena,
  output logic [`REG_AW-1:0] wb_fwd_addr,
  output logic [`XLEN-1:0]   wb_fwd_data,
  output logic               commit_valid,
  output logic [`REG_AW-1:0] commit_rd,
  output logic [`XLEN-1:0]   commit_data,
  output logic               commit_wen,
  output logic               commit_illegal,
  input  logic               commit_ready
);

  logic               mem_valid;
  logic [`XLEN-1:0]   mem_result;
  logic [`REG_AW-1:0] mem_rd;
  logic               mem_wen;
  logic               mem_illegal;
  logic               wb_valid;
  logic               wb_allowin;
  logic [`XLEN-1:0]   rf [0:(1<<`REG_AW)-1];

  assign wb_allowin  = !wb_valid || commit_ready;
  assign mem_allowin = !mem_valid || wb_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid <= 1'b0;
      wb_valid  <= 1'b0;
    end else begin
      if (mem_allowin) begin
        mem_valid <= ex_to_mem_valid;
      end
      if (wb_allowin) begin
        wb_valid <= mem_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ex_to_mem_valid && mem_allowin) begin
      mem_result  <= ex_result;
      mem_rd      <= ex_rd;
      mem_wen     <= ex_wen;
      mem_illegal <= ex_illegal;
    end
    if (mem_valid && wb_allowin) begin
      commit_data    <= mem_result;
      commit_rd      <= mem_rd;
      commit_wen     <= mem_wen;
      commit_illegal <= mem_illegal;
    end
  end

  assign commit_valid = wb_valid;

  // write on retirement, x0 stays untouched
  always_ff @(posedge clk) begin
    if (commit_valid && commit_ready && commit_wen && commit_rd != '0) begin
      rf[commit_rd] <= commit_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : rf[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : rf[rs2_addr];

  // x0 filtering happens at the consumer
  assign mem_fwd_ena  = mem_valid && mem_wen;
  assign mem_fwd_addr = mem_rd;
  assign mem_fwd_data = mem_result;
  assign wb_fwd_ena   = wb_valid && commit_wen;
  assign wb_fwd_addr  = commit_rd;
  assign wb_fwd_data  = commit_data;

endmodule

// ==== logic/ex_core_top.sv ====
// four-deep pipeline; with commit_ready held high an instruction retires four edges after issue
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_core_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  logic [`INST_W-1:0] in_inst,
  output logic               in_ready,
  output logic               commit_valid,
  output logic [`REG_AW-1:0] commit_rd,
  output logic [`XLEN-1:0]   commit_data,
  output logic               commit_wen,
  output logic               commit_illegal,
  input  logic               commit_ready
);

  // decode to execute
  logic               id_to_ex_valid;
  logic [3:0]         id_alu_op;
  logic [`REG_AW-1:0] id_rs1;
  logic [`REG_AW-1:0] id_rs2;
  logic               id_use_rs2;
  logic [`XLEN-1:0]   id_imm;
  logic               id_is_word;
  logic [`REG_AW-1:0] id_rd;
  logic               id_wen;
  logic               id_illegal;
  logic               ex_allowin;

  // execute to mem, plus reads and forwards
  logic               ex_to_mem_valid;
  logic [`XLEN-1:0]   ex_result;
  logic [`REG_AW-1:0] ex_rd;
  logic               ex_wen;
  logic               ex_illegal;
  logic               mem_allowin;
  logic [`REG_AW-1:0] rs1_addr;
  logic [`REG_AW-1:0] rs2_addr;
  logic [`XLEN-1:0]   rs1_data;
  logic [`XLEN-1:0]   rs2_data;
  logic               mem_fwd_ena;
  logic [`REG_AW-1:0] mem_fwd_addr;
  logic [`XLEN-1:0]   mem_fwd_data;
  logic               wb_fwd_ena;
  logic [`REG_AW-1:0] wb_fwd_addr;
  logic [`XLEN-1:0]   wb_fwd_data;

  id_decode u_id_decode (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_inst        (in_inst),
    .in_ready       (in_ready),
    .id_to_ex_valid (id_to_ex_valid),
    .id_alu_op      (id_alu_op),
    .id_rs1         (id_rs1),
    .id_rs2         (id_rs2),
    .id_use_rs2     (id_use_rs2),
    .id_imm         (id_imm),
    .id_is_word     (id_is_word),
    .id_rd          (id_rd),
    .id_wen         (id_wen),
    .id_illegal     (id_illegal),
    .ex_allowin     (ex_allowin)
  );

  ex_stage u_ex_stage (
    .clk             (clk),
    .rst             (rst),
    .id_to_ex_valid  (id_to_ex_valid),
    .id_alu_op       (id_alu_op),
    .id_rs1          (id_rs1),
    .id_rs2          (id_rs2),
    .id_use_rs2      (id_use_rs2),
    .id_imm          (id_imm),
    .id_is_word      (id_is_word),
    .id_rd           (id_rd),
    .id_wen          (id_wen),
    .id_illegal      (id_illegal),
    .ex_allowin      (ex_allowin),
    .rs1_addr        (rs1_addr),
    .rs2_addr        (rs2_addr),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .mem_fwd_ena     (mem_fwd_ena),
    .mem_fwd_addr    (mem_fwd_addr),
    .mem_fwd_data    (mem_fwd_data),
    .wb_fwd_ena      (wb_fwd_ena),
    .wb_fwd_addr     (wb_fwd_addr),
    .wb_fwd_data     (wb_fwd_data),
    .ex_to_mem_valid (ex_to_mem_valid),
    .ex_result       (ex_result),
    .ex_rd           (ex_rd),
    .ex_wen          (ex_wen),
    .ex_illegal      (ex_illegal),
    .mem_allowin     (mem_allowin)
  );

  wb_stage u_wb_stage (
    .clk             (clk),
    .rst             (rst),
    .ex_to_mem_valid (ex_to_mem_valid),
    .ex_result       (ex_result),
    .ex_rd           (ex_rd),
    .ex_wen          (ex_wen),
    .ex_illegal      (ex_illegal),
    .mem_allowin     (mem_allowin),
    .rs1_addr        (rs1_addr),
    .rs2_addr        (rs2_addr),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .mem_fwd_ena     (mem_fwd_ena),
    .mem_fwd_addr    (mem_fwd_addr),
    .mem_fwd_data    (mem_fwd_data),
    .wb_fwd_ena      (wb_fwd_ena),
    .wb_fwd_addr     (wb_fwd_addr),
    .wb_fwd_data     (wb_fwd_data),
    .commit_valid    (commit_valid),
    .commit_rd       (commit_rd),
    .commit_data     (commit_data),
    .commit_wen      (commit_wen),
    .commit_illegal  (commit_illegal),
    .commit_ready    (commit_ready)
  );

endmodule

// ==== verif/tb_checker.sv ====
// model starts with x1..x31 at zero; relies on the stimulus writing every register before it is read
`timescale 1ns/1ps
`include "ex_cfg.svh"

module tb_checker import ex_pkg::*; #(
  parameter int EXPECTED = 0
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  logic [`INST_W-1:0] in_inst,
  input  logic               in_ready,
  input  logic               commit_valid,
  input  logic [`REG_AW-1:0] commit_rd,
  input  logic [`XLEN-1:0]   commit_data,
  input  logic               commit_wen,
  input  logic               commit_illegal,
  input  logic               commit_ready,
  input  logic               end_of_test,
  output int                 value_errors,
  output int                 flow_errors,
  output int                 issued_count,
  output int                 retired_count,
  output logic               report_done
);

  logic [`INST_W-1:0] pending [$];
  logic [`XLEN-1:0]   regs [0:31];
  logic               saw_stall;

  // architectural result of one instruction, returns 1 when the encoding is supported
  function automatic logic model_exec(input logic [31:0] word, output logic [63:0] res);
    inst_u       iw;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm;
    logic [5:0]  sh;
    logic [31:0] w;
    logic        ok;
    iw  = word;
    a   = regs[iw.r_view.rs1];
    b   = regs[iw.r_view.rs2];
    imm = {{52{iw.i_view.imm12[11]}}, iw.i_view.imm12};
    sh  = iw.i_view.imm12[5:0];
    ok  = 1'b1;
    res = 64'b0;
    w   = 32'b0;
    case (iw.r_view.opcode)
      OPC_LUI: res = {{32{word[31]}}, word[31:12], 12'b0};
      OPC_OP_IMM: begin
        case (iw.i_view.funct3)
          3'b000: res = a + imm;
          3'b010: res = {63'b0, $signed(a) < $signed(imm)};
          3'b011: res = {63'b0, a < imm};
          3'b100: res = a ^ imm;
          3'b110: res = a | imm;
          3'b111: res = a & imm;
          3'b001: begin
            if (iw.i_view.imm12[11:6] == 6'b000000) res = a << sh;
            else ok = 1'b0;
          end
          default: begin
            if (iw.i_view.imm12[11:6] == 6'b000000) res = a >> sh;
            else if (iw.i_view.imm12[11:6] == 6'b010000) res = $signed(a) >>> sh;
            else ok = 1'b0;
          end
        endcase
      end
      OPC_OP: begin
        case ({iw.r_view.funct7, iw.r_view.funct3})
          {7'h00, 3'h0}: res = a + b;
          {7'h20, 3'h0}: res = a - b;
          {7'h00, 3'h1}: res = a << b[5:0];
          {7'h00, 3'h2}: res = {63'b0, $signed(a) < $signed(b)};
          {7'h00, 3'h3}: res = {63'b0, a < b};
          {7'h00, 3'h4}: res = a ^ b;
          {7'h00, 3'h5}: res = a >> b[5:0];
          {7'h20, 3'h5}: res = $signed(a) >>> b[5:0];
          {7'h00, 3'h6}: res = a | b;
          {7'h00, 3'h7}: res = a & b;
          default: ok = 1'b0;
        endcase
      end
      OPC_OP_IMM_32: begin
        // funct7 holds shamt[5] here, so it must be clear
        case ({iw.r_view.funct7, iw.r_view.funct3})
          {7'h00, 3'h1}: w = a[31:0] << sh[4:0];
          {7'h00, 3'h5}: w = a[31:0] >> sh[4:0];
          {7'h20, 3'h5}: w = $signed(a[31:0]) >>> sh[4:0];
          default: begin
            if (iw.i_view.funct3 == 3'b000) w = a[31:0] + imm[31:0];
            else ok = 1'b0;
          end
        endcase
        res = {{32{w[31]}}, w};
      end
      OPC_OP_32: begin
        case ({iw.r_view.funct7, iw.r_view.funct3})
          {7'h00, 3'h0}: w = a[31:0] + b[31:0];
          {7'h20, 3'h0}: w = a[31:0] - b[31:0];
          {7'h00, 3'h1}: w = a[31:0] << b[4:0];
          {7'h00, 3'h5}: w = a[31:0] >> b[4:0];
          {7'h20, 3'h5}: w = $signed(a[31:0]) >>> b[4:0];
          default: ok = 1'b0;
        endcase
        res = {{32{w[31]}}, w};
      end
      default: ok = 1'b0;
    endcase
    return ok;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic retire_one();
    logic [31:0] word;
    logic [63:0] exp_val;
    logic        legal;
    inst_u       iw;
    retired_count++;
    if (pending.size() == 0) begin
      $display("%0t: an instruction retired while none was waiting to retire", $time);
      flow_errors++;
    end else begin
      word  = pending.pop_front();
      iw    = word;
      legal = model_exec(word, exp_val);
      check_value("commit_rd", {59'b0, iw.r_view.rd}, {59'b0, commit_rd});
      check_value("commit_illegal", {63'b0, !legal}, {63'b0, commit_illegal});
      check_value("commit_wen", {63'b0, legal}, {63'b0, commit_wen});
      if (legal) check_value("commit_data", exp_val, commit_data);
      // x0 stays zero in the model
      if (legal && iw.r_view.rd != 5'd0) regs[iw.r_view.rd] = exp_val;
    end
  endtask

  task automatic final_checks();
    if (pending.size() != 0) begin
      $display("%0t: %0d accepted instructions never retired", $time, pending.size());
      flow_errors++;
    end
    if (issued_count != EXPECTED || retired_count != issued_count) begin
      $display("%0t: %0d instructions sent, %0d accepted, %0d retired", $time, EXPECTED,
               issued_count, retired_count);
      flow_errors++;
    end
    if (!saw_stall) begin
      $display("in_ready never dropped, so back-pressure was not exercised");
      flow_errors++;
    end
    report_done = 1'b1;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      value_errors  = 0;
      flow_errors   = 0;
      issued_count  = 0;
      retired_count = 0;
      report_done   = 1'b0;
      saw_stall     = 1'b0;
      for (int i = 0; i < 32; i++) regs[i] = 64'b0;
    end else begin
      if (in_ready === 1'b0) saw_stall = 1'b1;
      if (commit_valid && commit_ready) retire_one();
      if (in_valid && in_ready) begin
        pending.push_back(in_inst);
        issued_count++;
      end
      if (end_of_test && !report_done) final_checks();
    end
  end

endmodule

// ==== verif/tb_top.sv ====
// random stream from a 16-bit LFSR; warm-up writes x1..x31, later fields mostly use x0..x7
`timescale 1ns/1ps
`include "ex_cfg.svh"

module tb_top import ex_pkg::*; ();

  localparam int NUM_INST    = 2000;
  localparam int CLK_PERIOD  = 40;
  localparam int WATCHDOG_NS = NUM_INST * 10 * CLK_PERIOD;

  logic               clk;
  logic               rst;
  logic               in_valid;
  logic [`INST_W-1:0] in_inst;
  logic               in_ready;
  logic               commit_valid;
  logic [`REG_AW-1:0] commit_rd;
  logic [`XLEN-1:0]   commit_data;
  logic               commit_wen;
  logic               commit_illegal;
  logic               commit_ready;
  logic               end_of_test;
  logic               report_done;
  logic               fired;
  logic [15:0]        lfsr;
  int                 value_errors;
  int                 flow_errors;
  int                 issued_count;
  int                 retired_count;
  int                 gen_count;
  int                 stall_left;

  ex_core_top u_ex_core_top (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_inst        (in_inst),
    .in_ready       (in_ready),
    .commit_valid   (commit_valid),
    .commit_rd      (commit_rd),
    .commit_data    (commit_data),
    .commit_wen     (commit_wen),
    .commit_illegal (commit_illegal),
    .commit_ready   (commit_ready)
  );

  tb_checker #(.EXPECTED(NUM_INST)) u_tb_checker (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_inst        (in_inst),
    .in_ready       (in_ready),
    .commit_valid   (commit_valid),
    .commit_rd      (commit_rd),
    .commit_data    (commit_data),
    .commit_wen     (commit_wen),
    .commit_illegal (commit_illegal),
    .commit_ready   (commit_ready),
    .end_of_test    (end_of_test),
    .value_errors   (value_errors),
    .flow_errors    (flow_errors),
    .issued_count   (issued_count),
    .retired_count  (retired_count),
    .report_done    (report_done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic make_inst(input int idx, output logic [31:0] inst);
    logic [31:0] kind;
    logic [31:0] rdb;
    logic [31:0] r1b;
    logic [31:0] r2b;
    logic [31:0] imm;
    logic [31:0] sel;
    logic [31:0] alt;
    logic [31:0] up;
    logic [4:0]  rd5;
    logic [4:0]  r1;
    logic [4:0]  r2;
    logic [11:0] imm12;
    logic [6:0]  f7;
    logic [2:0]  fn3;
    rand_bits(4, kind);
    rand_bits(3, rdb);
    rand_bits(3, r1b);
    rand_bits(3, r2b);
    rand_bits(12, imm);
    rand_bits(3, sel);
    rand_bits(1, alt);
    rd5 = {2'b00, rdb[2:0]};
    r1  = {2'b00, r1b[2:0]};
    r2  = {2'b00, r2b[2:0]};
    fn3 = sel[2:0];
    if (idx < 31) begin
      // warm-up, addi x(idx+1), x0, imm
      rd5  = idx[4:0] + 5'd1;
      inst = {imm[11:0], 5'd0, 3'b000, rd5, OPC_OP_IMM};
    end else begin
      case (kind[3:0])
        4'd0, 4'd1, 4'd2, 4'd3: begin
          imm12 = imm[11:0];
          if (fn3 == 3'b001) imm12 = {6'b0, imm[5:0]};
          if (fn3 == 3'b101) imm12 = {1'b0, alt[0], 4'b0, imm[5:0]};
          inst = {imm12, r1, fn3, rd5, OPC_OP_IMM};
        end
        4'd4, 4'd5, 4'd6: begin
          f7   = (alt[0] && (fn3 == 3'b000 || fn3 == 3'b101)) ? 7'h20 : 7'h00;
          inst = {f7, r2, r1, fn3, rd5, OPC_OP};
        end
        4'd7, 4'd8: begin
          case (sel[1:0])
            2'd0: inst = {imm[11:0], r1, 3'b000, rd5, OPC_OP_IMM_32};
            2'd1: inst = {7'h00, imm[4:0], r1, 3'b001, rd5, OPC_OP_IMM_32};
            2'd2: inst = {7'h00, imm[4:0], r1, 3'b101, rd5, OPC_OP_IMM_32};
            default: inst = {7'h20, imm[4:0], r1, 3'b101, rd5, OPC_OP_IMM_32};
          endcase
        end
        4'd9, 4'd10: begin
          f7  = (sel == 1 || sel == 4) ? 7'h20 : 7'h00;
          fn3 = (sel == 2) ? 3'b001 : ((sel == 3 || sel == 4) ? 3'b101 : 3'b000);
          inst = {f7, r2, r1, fn3, rd5, OPC_OP_32};
        end
        4'd11, 4'd12: begin
          rand_bits(20, up);
          inst = {up[19:0], rd5, OPC_LUI};
        end
        // fully random word, mostly unsupported opcodes
        4'd13: rand_bits(32, inst);
        // multiply group, not supported
        4'd14: inst = {7'h01, r2, r1, fn3, rd5, OPC_OP};
        // slliw with shamt[5] set
        default: inst = {7'h01, imm[4:0], r1, 3'b001, rd5, OPC_OP_IMM_32};
      endcase
    end
  endtask

  // mostly ready, with occasional long stalls to back the pipeline up
  task automatic drive_ready();
    logic [31:0] roll;
    logic [31:0] len;
    if (stall_left > 0) begin
      commit_ready = 1'b0;
      stall_left--;
    end else begin
      rand_bits(5, roll);
      if (roll[4:0] == 5'd0) begin
        rand_bits(4, len);
        stall_left   = 8 + int'(len[3:0]);
        commit_ready = 1'b0;
      end else begin
        rand_bits(3, roll);
        commit_ready = (roll[2:0] != 3'd0);
      end
    end
  endtask

  // transfer decided on the rising edge, seen by the stimulus at the falling one
  always @(posedge clk) begin
    fired <= in_valid && in_ready;
  end

  initial begin
    logic [31:0] roll;
    logic [31:0] pick;
    lfsr         = 16'd75;
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_inst      = '0;
    commit_ready = 1'b0;
    end_of_test  = 1'b0;
    gen_count    = 0;
    stall_left   = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (!(gen_count == NUM_INST && !in_valid)) begin
      @(negedge clk);
      // hold the offered instruction until it is taken
      if (!in_valid || fired) begin
        in_valid = 1'b0;
        if (gen_count < NUM_INST) begin
          rand_bits(2, roll);
          if (roll[1:0] != 2'd0) begin
            make_inst(gen_count, pick);
            in_inst  = pick;
            in_valid = 1'b1;
            gen_count++;
          end
        end
      end
      drive_ready();
    end
    commit_ready = 1'b1;
    while (retired_count < NUM_INST) @(negedge clk);
    // extra cycles to catch duplicated retirements
    repeat (10) @(negedge clk);
    end_of_test = 1'b1;
    wait (report_done);
    @(negedge clk);
    $display("value errors %0d, flow errors %0d, retired %0d", value_errors, flow_errors,
             retired_count);
    if (value_errors == 0 && flow_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: not all instructions retired within %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+logic
logic/ex_pkg.sv
logic/id_decode.sv
logic/ex_alu.sv
logic/ex_stage.sv
logic/wb_stage.sv
logic/ex_core_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// ==== Makefile ====
SIM      = verilator
SIMFLAGS = --binary --timing -j 0
TOP      = tb_top
FILELIST = all.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
